//--- verilog/vec_acc_cfg.svh
// Vector accelerator sizing macros for lanes, vector registers and elements
`ifndef VEC_ACC_CFG_SVH
`define VEC_ACC_CFG_SVH

// Number of parallel vector lanes
// Must be a power of two
`define VEC_NR_LANES 2

// Bits per vector register
// Must be a power of two and at least VEC_ELEN times VEC_NR_LANES
`define VEC_VLEN 256

// Element width in bits
`define VEC_ELEN 32

// Number of architectural vector registers
// At most 8, register names are 3 bits wide
`define VEC_NR_VREGS 8

// Elements of one vector register held by each lane
`define VEC_ELEMS_PER_LANE (`VEC_VLEN / `VEC_ELEN / `VEC_NR_LANES)

// Width of the row index inside a lane, never below one bit
`define VEC_ROW_W ((`VEC_ELEMS_PER_LANE > 1) ? $clog2(`VEC_ELEMS_PER_LANE) : 1)

`endif

//--- verilog/vec_pkg.sv
// Vector accelerator types shared by the dispatcher, the lanes and the top level
`include "vec_acc_cfg.svh"

package vec_pkg;

  // One vector element, arithmetic wraps at this width
  typedef logic [`VEC_ELEN-1:0] elem_t;

  // Vector register name
  typedef logic [2:0] vreg_idx_t;

  // Row inside one lane's slice of a vector register
  typedef logic [`VEC_ROW_W-1:0] row_idx_t;

  // Supported instructions
  // Any other 4-bit code is carried as is and decodes as illegal
  typedef enum logic [3:0] {
    VMV_VX  = 4'h0,
    VADD_VX = 4'h1,
    VADD_VV = 4'h2,
    VAND_VV = 4'h3,
    VXOR_VV = 4'h4,
    VREDSUM = 4'h5,
    VMV_XS  = 4'h6
  } vec_op_e;

  // Request from the scalar core
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     rs1;
  } acc_req_t;

  // Response back to the scalar core
  typedef struct packed {
    elem_t result;
    logic  error;
  } acc_resp_t;

  // Command broadcast to every lane, one row per cycle
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
    row_idx_t  row;
    // Restarts the reduction accumulator
    logic      first;
  } lane_cmd_t;

  // Dispatcher sequencing
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN,
    RESP
  } disp_state_e;

endpackage : vec_pkg

//--- verilog/spill_register.sv
// Two-entry valid/ready buffer that registers both the data and the ready path
module spill_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i
);

  // Slot A takes new data, slot B catches it on a stall
  T     a_data_q;
  T     b_data_q;
  logic a_full_q;
  logic b_full_q;

  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  // Input transfer lands in A
  assign a_fill  = valid_i && ready_o;
  // A always empties while B is free, either downstream or into B
  assign a_drain = a_full_q && !b_full_q;
  // Downstream stalled, park A's entry in B
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  // Fill flags
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  // Payload slots
  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // B holds the older entry, so it goes out first
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  // Stop only once both slots are taken
  assign ready_o = !a_full_q || !b_full_q;

endmodule : spill_register

//--- verilog/vec_lane.sv
// Vector lane with its register file slice, integer ALU and reduction accumulator
`include "vec_acc_cfg.svh"

module vec_lane (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Broadcast command
  input  vec_pkg::lane_cmd_t lane_cmd_i,
  input  logic               lane_cmd_valid_i,
  // Registered partial sum
  output vec_pkg::elem_t     lane_acc_o,
  // Registered row 0 of vs2
  output vec_pkg::elem_t     lane_rd_o
);

  // Register file slice, one row per element this lane owns
  vec_pkg::elem_t vrf_q [`VEC_NR_VREGS][`VEC_ELEMS_PER_LANE];

  // Operands of the current row
  vec_pkg::elem_t op_a;
  vec_pkg::elem_t op_b;
  vec_pkg::elem_t alu_res;

  logic wr_en;
  logic red_en;

  vec_pkg::elem_t acc_q;
  vec_pkg::elem_t rd_q;

  // vs1 and vs2 read on the same row
  assign op_a = vrf_q[lane_cmd_i.vs1][lane_cmd_i.row];
  assign op_b = vrf_q[lane_cmd_i.vs2][lane_cmd_i.row];

  // Element-wise ALU
  always_comb begin
    case (lane_cmd_i.op)
      // Broadcast of the scalar
      vec_pkg::VMV_VX:  alu_res = lane_cmd_i.scalar;
      vec_pkg::VADD_VX: alu_res = op_b + lane_cmd_i.scalar;
      vec_pkg::VADD_VV: alu_res = op_b + op_a;
      vec_pkg::VAND_VV: alu_res = op_b & op_a;
      vec_pkg::VXOR_VV: alu_res = op_b ^ op_a;
      // Reduction and readback write nothing
      default:          alu_res = op_b;
    endcase
  end

  // Only element-wise ops touch vd
  assign wr_en = lane_cmd_valid_i &&
                 (lane_cmd_i.op inside {vec_pkg::VMV_VX, vec_pkg::VADD_VX,
                                        vec_pkg::VADD_VV, vec_pkg::VAND_VV,
                                        vec_pkg::VXOR_VV});

  assign red_en = lane_cmd_valid_i && (lane_cmd_i.op == vec_pkg::VREDSUM);

  // Registers read as zero until written
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int r = 0; r < `VEC_NR_VREGS; r++) begin
        for (int e = 0; e < `VEC_ELEMS_PER_LANE; e++) begin
          vrf_q[r][e] <= '0;
        end
      end
    end else if (wr_en) begin
      // Read and write hit the same row, so in-place ops are safe
      vrf_q[lane_cmd_i.vd][lane_cmd_i.row] <= alu_res;
    end
  end

  // Partial sum and element 0 readback
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_q <= '0;
      rd_q  <= '0;
    end else begin
      if (red_en) begin
        // First row restarts the sum
        acc_q <= (lane_cmd_i.first ? '0 : acc_q) + op_b;
      end
      if (lane_cmd_valid_i) begin
        rd_q <= vrf_q[lane_cmd_i.vs2][0];
      end
    end
  end

  assign lane_acc_o = acc_q;
  assign lane_rd_o  = rd_q;

endmodule : vec_lane

//--- verilog/vec_dispatcher.sv
// Vector dispatcher that decodes requests, sequences lane rows and builds responses
`include "vec_acc_cfg.svh"

module vec_dispatcher (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Request side
  input  vec_pkg::acc_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  // Response side
  output vec_pkg::acc_resp_t acc_resp_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i,
  // Lane broadcast
  output vec_pkg::lane_cmd_t lane_cmd_o,
  output logic               lane_cmd_valid_o,
  // Lane results
  input  vec_pkg::elem_t     lane_acc_i [`VEC_NR_LANES],
  input  vec_pkg::elem_t     lane_rd_i  [`VEC_NR_LANES]
);

  vec_pkg::disp_state_e state_q;
  vec_pkg::disp_state_e state_d;

  // Latched request and decode
  vec_pkg::acc_req_t req_q;
  logic              illegal_q;
  logic              req_legal;
  logic              req_hs;

  // Row sequencing
  vec_pkg::row_idx_t row_q;
  logic              last_row;

  // Result path
  vec_pkg::elem_t red_sum;
  vec_pkg::elem_t result_q;

  // Only one instruction in flight
  assign acc_req_ready_o = (state_q == vec_pkg::IDLE);
  assign req_hs          = acc_req_valid_i && acc_req_ready_o;

  assign req_legal = acc_req_i.op inside {vec_pkg::VMV_VX, vec_pkg::VADD_VX,
                                          vec_pkg::VADD_VV, vec_pkg::VAND_VV,
                                          vec_pkg::VXOR_VV, vec_pkg::VREDSUM,
                                          vec_pkg::VMV_XS};

  assign last_row = (row_q == vec_pkg::row_idx_t'(`VEC_ELEMS_PER_LANE - 1));

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      vec_pkg::IDLE: begin
        if (req_hs) begin
          // Element 0 readback and illegal codes need no row pass
          if (!req_legal || acc_req_i.op == vec_pkg::VMV_XS) begin
            state_d = vec_pkg::DRAIN;
          end else begin
            state_d = vec_pkg::ISSUE;
          end
        end
      end
      vec_pkg::ISSUE: begin
        if (last_row) begin
          state_d = vec_pkg::DRAIN;
        end
      end
      vec_pkg::DRAIN: state_d = vec_pkg::RESP;
      vec_pkg::RESP: begin
        if (acc_resp_ready_i) begin
          state_d = vec_pkg::IDLE;
        end
      end
      default: state_d = vec_pkg::IDLE;
    endcase
  end

  // Control registers
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= vec_pkg::IDLE;
      row_q     <= '0;
      illegal_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (req_hs) begin
        illegal_q <= !req_legal;
        row_q     <= '0;
      end else if (state_q == vec_pkg::ISSUE) begin
        row_q <= row_q + vec_pkg::row_idx_t'(1);
      end
    end
  end

  // Modulo sum of the lane partial sums
  always_comb begin
    red_sum = '0;
    for (int l = 0; l < `VEC_NR_LANES; l++) begin
      red_sum = red_sum + lane_acc_i[l];
    end
  end

  // Request copy and reduction result
  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      req_q <= acc_req_i;
    end
    // Lane accumulators settled after the last row
    if (state_q == vec_pkg::DRAIN) begin
      result_q <= (req_q.op == vec_pkg::VREDSUM) ? red_sum : '0;
    end
  end

  // One row per cycle in ISSUE
  // VMV_XS sends a lone row-0 read in DRAIN
  assign lane_cmd_valid_o = (state_q == vec_pkg::ISSUE) ||
                            (state_q == vec_pkg::DRAIN && !illegal_q &&
                             req_q.op == vec_pkg::VMV_XS);

  assign lane_cmd_o.op     = req_q.op;
  assign lane_cmd_o.vd     = req_q.vd;
  assign lane_cmd_o.vs1    = req_q.vs1;
  assign lane_cmd_o.vs2    = req_q.vs2;
  assign lane_cmd_o.scalar = req_q.rs1;
  assign lane_cmd_o.row    = (state_q == vec_pkg::ISSUE) ? row_q : '0;
  assign lane_cmd_o.first  = (state_q == vec_pkg::DRAIN) || (row_q == '0);

  // Element 0 lives in lane 0, its read register is stable through RESP
  assign acc_resp_valid_o  = (state_q == vec_pkg::RESP);
  assign acc_resp_o.result = (!illegal_q && req_q.op == vec_pkg::VMV_XS) ?
                             lane_rd_i[0] : result_q;
  assign acc_resp_o.error  = illegal_q;

endmodule : vec_dispatcher

//--- verilog/vec_acc.sv
// Vector accelerator top level joining the core interface buffers and the lanes
`include "vec_acc_cfg.svh"

module vec_acc (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Request from the scalar core
  input  vec_pkg::acc_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  // Response to the scalar core
  output vec_pkg::acc_resp_t acc_resp_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i
);

  // Request path after the input buffer
  vec_pkg::acc_req_t  acc_req;
  logic               acc_req_valid;
  logic               acc_req_ready;

  // Response path before the output buffer
  vec_pkg::acc_resp_t acc_resp;
  logic               acc_resp_valid;
  logic               acc_resp_ready;

  // Lane broadcast and lane results
  vec_pkg::lane_cmd_t lane_cmd;
  logic               lane_cmd_valid;
  vec_pkg::elem_t     lane_acc [`VEC_NR_LANES];
  vec_pkg::elem_t     lane_rd  [`VEC_NR_LANES];

  spill_register #(
    .T(vec_pkg::acc_req_t)
  ) i_acc_req_register (
    .clk_i   (clk_i          ),
    .arst_n_i(arst_n_i       ),
    .data_i  (acc_req_i      ),
    .valid_i (acc_req_valid_i),
    .ready_o (acc_req_ready_o),
    .data_o  (acc_req        ),
    .valid_o (acc_req_valid  ),
    .ready_i (acc_req_ready  )
  );

  vec_dispatcher i_dispatcher (
    .clk_i           (clk_i         ),
    .arst_n_i        (arst_n_i      ),
    .acc_req_i       (acc_req       ),
    .acc_req_valid_i (acc_req_valid ),
    .acc_req_ready_o (acc_req_ready ),
    .acc_resp_o      (acc_resp      ),
    .acc_resp_valid_o(acc_resp_valid),
    .acc_resp_ready_i(acc_resp_ready),
    .lane_cmd_o      (lane_cmd      ),
    .lane_cmd_valid_o(lane_cmd_valid),
    .lane_acc_i      (lane_acc      ),
    .lane_rd_i       (lane_rd       )
  );

  // Every lane sees the same command, each owns every NR_LANES-th element
  for (genvar l = 0; l < `VEC_NR_LANES; l++) begin : g_lane
    vec_lane i_lane (
      .clk_i           (clk_i         ),
      .arst_n_i        (arst_n_i      ),
      .lane_cmd_i      (lane_cmd      ),
      .lane_cmd_valid_i(lane_cmd_valid),
      .lane_acc_o      (lane_acc[l]   ),
      .lane_rd_o       (lane_rd[l]    )
    );
  end

  spill_register #(
    .T(vec_pkg::acc_resp_t)
  ) i_acc_resp_register (
    .clk_i   (clk_i           ),
    .arst_n_i(arst_n_i        ),
    .data_i  (acc_resp        ),
    .valid_i (acc_resp_valid  ),
    .ready_o (acc_resp_ready  ),
    .data_o  (acc_resp_o      ),
    .valid_o (acc_resp_valid_o),
    .ready_i (acc_resp_ready_i)
  );

endmodule : vec_acc

//--- dv/clk_rst_gen.sv
// Testbench clock and reset source, free running clock and a held low reset
module clk_rst_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Symmetric clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset held for a fixed number of rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    // Release away from the active edge
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule : clk_rst_gen

//--- dv/vec_acc_tb.sv
// Vector accelerator testbench with a register file model and response checking
`include "vec_acc_cfg.svh"

module vec_acc_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 10;
  localparam int RST_CYCLES = 16;
  localparam int SEED       = 74425;
  localparam int NR_ELEMS   = `VEC_VLEN / `VEC_ELEN;

  // Requests per test
  localparam int N_ARITH = 40;
  localparam int N_RED   = 10;
  localparam int N_ILL   = 6;
  localparam int N_BP    = 40;
  localparam int N_INPL  = 12;
  localparam int N_REQS  = 4 * `VEC_NR_VREGS + 3 * N_ARITH + 2 * N_RED + 3 * N_ILL +
                           N_BP + 2 * N_INPL;
  // Generous per-request budget, back-pressure stretches included
  localparam int WATCHDOG_CYCLES = N_REQS * 20 + RST_CYCLES;

  logic               clk;
  logic               arst_n;
  vec_pkg::acc_req_t  acc_req;
  logic               acc_req_valid;
  logic               acc_req_ready;
  vec_pkg::acc_resp_t acc_resp;
  logic               acc_resp_valid;
  logic               acc_resp_ready;

  // Expected responses in issue order
  vec_pkg::acc_resp_t exp_q [$];
  // Model register file, element e of register r at vrf_m[r][e]
  vec_pkg::elem_t     vrf_m [`VEC_NR_VREGS][NR_ELEMS];

  int   seed    = SEED;
  int   bp_seed = SEED;
  logic bp_mode = 1'b0;
  int   stretch = 0;
  int   n_checks = 0;
  int   n_errors = 0;
  int   n_tests  = 0;
  int   chk0;
  int   err0;

  clk_rst_gen #(
    .PERIOD_NS (CLK_PERIOD),
    .RST_CYCLES(RST_CYCLES)
  ) i_clk_rst_gen (
    .clk_o  (clk   ),
    .rst_n_o(arst_n)
  );

  vec_acc uut (
    .clk_i           (clk           ),
    .arst_n_i        (arst_n        ),
    .acc_req_i       (acc_req       ),
    .acc_req_valid_i (acc_req_valid ),
    .acc_req_ready_o (acc_req_ready ),
    .acc_resp_o      (acc_resp      ),
    .acc_resp_valid_o(acc_resp_valid),
    .acc_resp_ready_i(acc_resp_ready)
  );

  // Uniform value in 0 .. n-1
  function automatic int rand_range(inout int s, input int n);
    int r;
    r = $random(s);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  function automatic vec_pkg::elem_t rand_elem(inout int s);
    return vec_pkg::elem_t'($random(s));
  endfunction

  function automatic vec_pkg::vec_op_e pick_op(input int i);
    case (i)
      0:       return vec_pkg::VMV_VX;
      1:       return vec_pkg::VADD_VX;
      2:       return vec_pkg::VADD_VV;
      3:       return vec_pkg::VAND_VV;
      4:       return vec_pkg::VXOR_VV;
      5:       return vec_pkg::VREDSUM;
      default: return vec_pkg::VMV_XS;
    endcase
  endfunction

  function automatic vec_pkg::acc_req_t make_req(input vec_pkg::vec_op_e op, input int vd,
                                                 input int vs1, input int vs2,
                                                 input vec_pkg::elem_t rs1);
    vec_pkg::acc_req_t req;
    req.op  = op;
    req.vd  = vec_pkg::vreg_idx_t'(vd);
    req.vs1 = vec_pkg::vreg_idx_t'(vs1);
    req.vs2 = vec_pkg::vreg_idx_t'(vs2);
    req.rs1 = rs1;
    return req;
  endfunction

  // Reference model, returns the expected response and updates vrf_m
  // Element 0 sits in lane 0 row 0, so VMV_XS reads vrf_m[vs2][0]
  function automatic vec_pkg::acc_resp_t exp_result(input vec_pkg::acc_req_t req);
    vec_pkg::acc_resp_t resp;
    vec_pkg::elem_t     sum;
    resp.result = '0;
    resp.error  = 1'b0;
    sum         = '0;
    // Same element index on both sides, in-place ops need no copy
    for (int e = 0; e < NR_ELEMS; e++) begin
      case (req.op)
        vec_pkg::VMV_VX:  vrf_m[req.vd][e] = req.rs1;
        vec_pkg::VADD_VX: vrf_m[req.vd][e] = vrf_m[req.vs2][e] + req.rs1;
        vec_pkg::VADD_VV: vrf_m[req.vd][e] = vrf_m[req.vs2][e] + vrf_m[req.vs1][e];
        vec_pkg::VAND_VV: vrf_m[req.vd][e] = vrf_m[req.vs2][e] & vrf_m[req.vs1][e];
        vec_pkg::VXOR_VV: vrf_m[req.vd][e] = vrf_m[req.vs2][e] ^ vrf_m[req.vs1][e];
        // Wraps at ELEN bits
        vec_pkg::VREDSUM: sum = sum + vrf_m[req.vs2][e];
        vec_pkg::VMV_XS:  resp.result = vrf_m[req.vs2][0];
        // Unknown code leaves the model untouched
        default:          resp.error = 1'b1;
      endcase
    end
    if (req.op == vec_pkg::VREDSUM) begin
      resp.result = sum;
    end
    return resp;
  endfunction

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_req(input vec_pkg::acc_req_t req);
    exp_q.push_back(exp_result(req));
    acc_req       = req;
    acc_req_valid = 1'b1;
    // Ready only moves on rising edges, so it is stable here
    while (!acc_req_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    acc_req_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  task automatic start_test();
    chk0 = n_checks;
    err0 = n_errors;
  endtask

  task automatic end_test(input string name);
    wait_drain();
    n_tests++;
    $display("test %s done: %0d checks, %0d errors", name, n_checks - chk0, n_errors - err0);
  endtask

  // Response ready and comparison share one process
  // Ready is set first, then the transfer at the coming rising edge is checked
  always @(negedge clk) begin
    vec_pkg::acc_resp_t exp;
    if (bp_mode) begin
      if (stretch == 0) begin
        acc_resp_ready = ~acc_resp_ready;
        stretch        = 1 + rand_range(bp_seed, 8);
      end else begin
        stretch--;
      end
    end else begin
      acc_resp_ready = 1'b1;
    end
    if (arst_n && acc_resp_valid && acc_resp_ready) begin
      n_checks++;
      assert (exp_q.size() != 0) else begin
        $display("Response arrived with no request outstanding");
        n_errors++;
      end
      if (exp_q.size() != 0) begin
        exp = exp_q.pop_front();
        assert (acc_resp.result == exp.result) else begin
          $display("MISMATCH acc_resp_o.result got %h expected %h", acc_resp.result,
                   exp.result);
          n_errors++;
        end
        assert (acc_resp.error == exp.error) else begin
          $display("MISMATCH acc_resp_o.error got %h expected %h", acc_resp.error, exp.error);
          n_errors++;
        end
      end
    end
  end

  // A lost response shows up here
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired with %0d responses still missing", exp_q.size());
    $display("Test failures found");
    $finish;
  end

  initial begin
    int r;
    int o;
    int m;
    int code;
    vec_pkg::vec_op_e op;
    vec_pkg::elem_t   v;
    acc_req        = '0;
    acc_req_valid  = 1'b0;
    acc_resp_ready = 1'b1;
    for (int i = 0; i < `VEC_NR_VREGS; i++) begin
      for (int e = 0; e < NR_ELEMS; e++) begin
        vrf_m[i][e] = '0;
      end
    end
    @(posedge arst_n);
    @(negedge clk);
    n_checks++;
    assert (acc_req_ready && !acc_resp_valid) else begin
      $display("DUT is not idle after reset");
      n_errors++;
    end

    // Zero after reset, then broadcast and readback
    start_test();
    for (int i = 0; i < `VEC_NR_VREGS; i++) begin
      send_req(make_req(vec_pkg::VMV_XS, 0, 0, i, '0));
      send_req(make_req(vec_pkg::VREDSUM, 0, 0, i, '0));
    end
    for (int i = 0; i < `VEC_NR_VREGS; i++) begin
      send_req(make_req(vec_pkg::VMV_VX, i, 0, 0, rand_elem(seed)));
      send_req(make_req(vec_pkg::VMV_XS, 0, 0, i, '0));
    end
    end_test("broadcast");

    // Random element-wise ops, each read back twice
    start_test();
    for (int i = 0; i < N_ARITH; i++) begin
      op = pick_op(1 + rand_range(seed, 4));
      r  = rand_range(seed, `VEC_NR_VREGS);
      send_req(make_req(op, r, rand_range(seed, 8), rand_range(seed, 8), rand_elem(seed)));
      send_req(make_req(vec_pkg::VMV_XS, 0, 0, r, '0));
      send_req(make_req(vec_pkg::VREDSUM, 0, 0, r, '0));
    end
    end_test("arith");

    // Every op treats all elements alike, so a sum short of one lane
    // differs from the full sum for odd values
    start_test();
    for (int i = 0; i < N_RED; i++) begin
      r = rand_range(seed, `VEC_NR_VREGS);
      v = rand_elem(seed) | 32'h1;
      send_req(make_req(vec_pkg::VMV_VX, r, 0, 0, v));
      send_req(make_req(vec_pkg::VREDSUM, 0, 0, r, '0));
    end
    end_test("reduce");

    // Codes above VMV_XS are unused
    start_test();
    for (int i = 0; i < N_ILL; i++) begin
      code = 7 + rand_range(seed, 9);
      r    = rand_range(seed, `VEC_NR_VREGS);
      op   = vec_pkg::vec_op_e'(4'(code));
      send_req(make_req(op, r, rand_range(seed, 8), rand_range(seed, 8), rand_elem(seed)));
      send_req(make_req(vec_pkg::VREDSUM, 0, 0, r, '0));
      send_req(make_req(vec_pkg::VMV_XS, 0, 0, r, '0));
    end
    end_test("illegal");

    // Response ready toggles in random stretches
    start_test();
    bp_mode = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      op = pick_op(rand_range(seed, 7));
      send_req(make_req(op, rand_range(seed, 8), rand_range(seed, 8), rand_range(seed, 8),
                        rand_elem(seed)));
    end
    wait_drain();
    bp_mode = 1'b0;
    end_test("backpressure");

    // Destination aliases one or both sources
    start_test();
    for (int i = 0; i < N_INPL; i++) begin
      op = pick_op(1 + rand_range(seed, 4));
      r  = rand_range(seed, `VEC_NR_VREGS);
      o  = rand_range(seed, `VEC_NR_VREGS);
      m  = rand_range(seed, 3);
      if (m == 0) begin
        send_req(make_req(op, r, r, o, rand_elem(seed)));
      end else if (m == 1) begin
        send_req(make_req(op, r, o, r, rand_elem(seed)));
      end else begin
        send_req(make_req(op, r, r, r, rand_elem(seed)));
      end
      send_req(make_req(vec_pkg::VREDSUM, 0, 0, r, '0));
    end
    end_test("in_place");

    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : vec_acc_tb

//--- project.f
+incdir+verilog
verilog/vec_pkg.sv
verilog/spill_register.sv
verilog/vec_lane.sv
verilog/vec_dispatcher.sv
verilog/vec_acc.sv
dv/clk_rst_gen.sv
dv/vec_acc_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the vec_acc simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module vec_acc_tb -o vec_acc_sim

out="$(./obj_dir/vec_acc_sim)"
echo "$out"

if echo "$out" | grep -qF "All tests passed!"; then
  exit 0
else
  exit 1
fi
